//--- include/k6502_defs.svh
`ifndef K6502_DEFS_SVH
`define K6502_DEFS_SVH

// Bus widths
`define K6502_DATA_W 8
`define K6502_ADDR_W 16

// Reset vector, low byte first
`define K6502_RST_VEC 16'hFFFC

// Zero page sits in the bottom 256 bytes
`define K6502_ZP_BASE 16'h0000

// Microcode step counter
`define K6502_CYC_W 3

// Status byte bit positions
`define K6502_FLAG_N 7
`define K6502_FLAG_V 6
`define K6502_FLAG_Z 1
`define K6502_FLAG_C 0

`endif

//--- src/k6502Pkg.sv
`include "k6502_defs.svh"

package k6502Pkg;

	typedef enum logic [3:0] {
		OpOr,
		OpAnd,
		OpEor,
		OpAdd,
		OpSub,
		OpCmp,
		OpAsl,
		OpRol,
		OpLsr,
		OpRor,
		OpInc,
		OpDec,
		OpTst,
		OpNone
	} aluOp_t;

	typedef enum logic [1:0] {
		RegA,
		RegX,
		RegY,
		RegNone
	} regSel_t;

	// Source of the internal data bus
	typedef enum logic [1:0] {
		DataIn,
		DataAlu,
		DataReg
	} dataSel_t;

	typedef enum logic [1:0] {
		AddrPc,
		AddrZp,
		AddrVec
	} addrSel_t;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flagMask_t;

	typedef struct packed {
		aluOp_t    aluOp;
		regSel_t   aluSrc;
		dataSel_t  dataSel;
		regSel_t   regDest;
		flagMask_t flagMask;
		logic [1:0] setFlags;   // bit 1 sets C, bit 0 clears C
		logic      clrV;
		addrSel_t  addrSel;
		logic      memWrite;
		logic      pcInc;
		logic      dlLoad;
		logic      pcLoadRel;
		logic      pcLoadAbs;
		logic      last;
		logic      illegal;
	} ctrlWord_t;

	typedef struct packed {
		logic [`K6502_ADDR_W-1:0] addr;
		logic                     write;
		logic [`K6502_DATA_W-1:0] wdata;
	} memReq_t;

	// Bits 5..2 carry no state in this core, bit 5 reads as one
	typedef struct packed {
		logic       n;
		logic       v;
		logic [3:0] fixed;
		logic       z;
		logic       c;
	} status_t;

endpackage

//--- src/k6502Alu.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Alu (
	input  k6502Pkg::aluOp_t           op,
	input  logic [`K6502_DATA_W-1:0]   a,
	input  logic [`K6502_DATA_W-1:0]   b,
	input  logic                       carryIn,
	output logic [`K6502_DATA_W-1:0]   result,
	output k6502Pkg::flagMask_t        flags
);
	import k6502Pkg::*;

	logic [`K6502_DATA_W:0] sum;

	always_comb begin
		sum     = '0;
		result  = a;
		flags.v = 1'b0;
		flags.c = carryIn;
		case (op)
			OpOr:  result = a | b;
			OpAnd: result = a & b;
			OpEor: result = a ^ b;
			OpAdd: begin
				sum     = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};
				result  = sum[7:0];
				flags.c = sum[8];
				flags.v = (a[7] == b[7]) && (sum[7] != a[7]);
			end
			// Borrow is the inverted carry
			OpSub: begin
				sum     = {1'b0, a} + {1'b0, ~b} + {8'd0, carryIn};
				result  = sum[7:0];
				flags.c = sum[8];
				flags.v = (a[7] != b[7]) && (sum[7] != a[7]);
			end
			OpCmp: begin
				sum     = {1'b0, a} + {1'b0, ~b} + 9'd1;
				result  = sum[7:0];
				flags.c = sum[8];
			end
			OpAsl: {flags.c, result} = {a, 1'b0};
			OpRol: {flags.c, result} = {a, carryIn};
			OpLsr: {result, flags.c} = {1'b0, a};
			OpRor: {result, flags.c} = {carryIn, a};
			OpInc: result = a + 8'd1;
			OpDec: result = a - 8'd1;
			default: result = a;
		endcase
		flags.n = result[7];
		flags.z = (result == '0);
	end

endmodule

//--- src/k6502Decode.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Decode (
	input  logic [7:0]               ir,
	input  logic [`K6502_CYC_W-1:0]  cycle,
	input  k6502Pkg::status_t        status,
	output k6502Pkg::ctrlWord_t      ctrl
);
	import k6502Pkg::*;

	aluOp_t grpOp;
	logic   brFlag;
	logic   brTaken;

	// Which flags each ALU operation writes back
	function automatic flagMask_t maskOf(input aluOp_t op);
		flagMask_t m;
		m = '0;
		case (op)
			OpOr, OpAnd, OpEor, OpInc, OpDec, OpTst: m = '{n: 1'b1, v: 1'b0, z: 1'b1, c: 1'b0};
			OpAdd, OpSub: m = '{n: 1'b1, v: 1'b1, z: 1'b1, c: 1'b1};
			OpCmp, OpAsl, OpRol, OpLsr, OpRor: m = '{n: 1'b1, v: 1'b0, z: 1'b1, c: 1'b1};
			default: m = '0;
		endcase
		return m;
	endfunction

	// ALU operation from the cc=01 and cc=10 opcode groups
	always_comb begin
		casez (ir)
			8'b000???01: grpOp = OpOr;
			8'b001???01: grpOp = OpAnd;
			8'b010???01: grpOp = OpEor;
			8'b011???01: grpOp = OpAdd;
			8'b110???01: grpOp = OpCmp;
			8'b111???01: grpOp = OpSub;
			8'b000???10: grpOp = OpAsl;
			8'b001???10: grpOp = OpRol;
			8'b010???10: grpOp = OpLsr;
			8'b011???10: grpOp = OpRor;
			default:     grpOp = OpNone;
		endcase
	end

	// ir[7:6] picks the flag, ir[5] the value it must have
	always_comb begin
		case (ir[7:6])
			2'b00:   brFlag = status[`K6502_FLAG_N];
			2'b01:   brFlag = status[`K6502_FLAG_V];
			2'b10:   brFlag = status[`K6502_FLAG_C];
			default: brFlag = status[`K6502_FLAG_Z];
		endcase
		brTaken = (brFlag == ir[5]);
	end

	always_comb begin
		ctrl = '{aluOp: OpNone, aluSrc: RegNone, dataSel: DataIn, regDest: RegNone,
			flagMask: '0, setFlags: 2'b00, addrSel: AddrPc, default: 1'b0};
		if (cycle == '0) begin
			// Opcode fetch
			ctrl.pcInc = 1'b1;
		end else if (cycle == `K6502_CYC_W'(1)) begin
			case (ir) inside
				8'h09, 8'h29, 8'h49, 8'h69, 8'hC9, 8'hE9: begin
					ctrl.aluOp   = grpOp;
					ctrl.aluSrc  = RegA;
					ctrl.dataSel = DataAlu;
					ctrl.regDest = (grpOp == OpCmp) ? RegNone : RegA;
					ctrl.pcInc   = 1'b1;
					ctrl.last    = 1'b1;
				end
				8'hE0, 8'hC0: begin
					ctrl.aluOp  = OpCmp;
					ctrl.aluSrc = ir[5] ? RegX : RegY;
					ctrl.pcInc  = 1'b1;
					ctrl.last   = 1'b1;
				end
				8'h0A, 8'h2A, 8'h4A, 8'h6A: begin
					ctrl.aluOp   = grpOp;
					ctrl.aluSrc  = RegA;
					ctrl.dataSel = DataAlu;
					ctrl.regDest = RegA;
					ctrl.last    = 1'b1;
				end
				8'hA9, 8'hA2, 8'hA0: begin
					ctrl.aluOp   = OpTst;
					ctrl.dataSel = DataAlu;
					ctrl.regDest = (ir == 8'hA9) ? RegA : (ir == 8'hA2) ? RegX : RegY;
					ctrl.pcInc   = 1'b1;
					ctrl.last    = 1'b1;
				end
				// Zero-page operand byte
				8'hA5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84, 8'h4C: begin
					ctrl.pcInc  = 1'b1;
					ctrl.dlLoad = 1'b1;
				end
				8'hE8, 8'hC8, 8'hCA, 8'h88: begin
					ctrl.aluOp   = (ir == 8'hE8 || ir == 8'hC8) ? OpInc : OpDec;
					ctrl.aluSrc  = (ir == 8'hE8 || ir == 8'hCA) ? RegX : RegY;
					ctrl.regDest = ctrl.aluSrc;
					ctrl.dataSel = DataAlu;
					ctrl.last    = 1'b1;
				end
				8'hAA, 8'hA8, 8'h8A, 8'h98: begin
					ctrl.aluOp   = OpTst;
					ctrl.aluSrc  = (ir == 8'h8A) ? RegX : (ir == 8'h98) ? RegY : RegA;
					ctrl.regDest = (ir == 8'hAA) ? RegX : (ir == 8'hA8) ? RegY : RegA;
					ctrl.dataSel = DataAlu;
					ctrl.last    = 1'b1;
				end
				8'h18: begin
					ctrl.setFlags = 2'b01;
					ctrl.last     = 1'b1;
				end
				8'h38: begin
					ctrl.setFlags = 2'b10;
					ctrl.last     = 1'b1;
				end
				8'hB8: begin
					ctrl.clrV = 1'b1;
					ctrl.last = 1'b1;
				end
				8'hEA: ctrl.last = 1'b1;
				8'b???10000: begin
					ctrl.pcInc  = 1'b1;
					ctrl.dlLoad = 1'b1;
					ctrl.last   = ~brTaken;
				end
				default: ctrl.illegal = 1'b1;
			endcase
		end else if (cycle == `K6502_CYC_W'(2)) begin
			case (ir) inside
				8'hA5, 8'hA6, 8'hA4: begin
					ctrl.addrSel = AddrZp;
					ctrl.aluOp   = OpTst;
					ctrl.dataSel = DataAlu;
					ctrl.regDest = (ir == 8'hA5) ? RegA : (ir == 8'hA6) ? RegX : RegY;
					ctrl.last    = 1'b1;
				end
				8'h85, 8'h86, 8'h84: begin
					ctrl.addrSel  = AddrZp;
					ctrl.memWrite = 1'b1;
					ctrl.aluSrc   = (ir == 8'h85) ? RegA : (ir == 8'h86) ? RegX : RegY;
					ctrl.dataSel  = DataReg;
					ctrl.last     = 1'b1;
				end
				8'h4C: begin
					ctrl.pcLoadAbs = 1'b1;
					ctrl.last      = 1'b1;
				end
				8'b???10000: begin
					ctrl.pcLoadRel = 1'b1;
					ctrl.last      = 1'b1;
				end
				default: ctrl.illegal = 1'b1;
			endcase
		end else begin
			ctrl.illegal = 1'b1;
		end
		ctrl.flagMask = maskOf(ctrl.aluOp);
	end

endmodule

//--- src/k6502Regs.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Regs (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       step,
	input  k6502Pkg::ctrlWord_t        ctrl,
	input  logic [`K6502_DATA_W-1:0]   aluResult,
	input  k6502Pkg::flagMask_t        aluFlags,
	input  logic [`K6502_DATA_W-1:0]   dataIn,
	output logic [`K6502_DATA_W-1:0]   regData,
	output logic [`K6502_DATA_W-1:0]   aluOperand,
	output k6502Pkg::status_t          status
);
	import k6502Pkg::*;

	logic [`K6502_DATA_W-1:0] regA, regX, regY;
	logic [`K6502_DATA_W-1:0] wrVal;

	always_comb begin
		case (ctrl.aluSrc)
			RegA:    regData = regA;
			RegX:    regData = regX;
			RegY:    regData = regY;
			default: regData = '0;
		endcase
		// Loads test the incoming byte itself
		aluOperand = (ctrl.aluSrc == RegNone) ? dataIn : regData;
		case (ctrl.dataSel)
			DataAlu: wrVal = aluResult;
			DataReg: wrVal = regData;
			default: wrVal = dataIn;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regA   <= '0;
			regX   <= '0;
			regY   <= '0;
			status <= '{n: 1'b0, v: 1'b0, fixed: 4'b1000, z: 1'b0, c: 1'b0};
		end else if (step) begin
			case (ctrl.regDest)
				RegA: regA <= wrVal;
				RegX: regX <= wrVal;
				RegY: regY <= wrVal;
				default: ;
			endcase
			if (ctrl.flagMask.n)
				status.n <= aluFlags.n;
			if (ctrl.flagMask.z)
				status.z <= aluFlags.z;
			if (ctrl.flagMask.v || ctrl.clrV)
				status.v <= aluFlags.v & ~ctrl.clrV;
			// SEC and CLC
			if (ctrl.flagMask.c)
				status.c <= aluFlags.c;
			else if (ctrl.setFlags != 2'b00)
				status.c <= ctrl.setFlags[1];
		end
	end

endmodule

//--- src/k6502Seq.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Seq (
	input  logic                       clk,
	input  logic                       rstN,
	input  k6502Pkg::ctrlWord_t        ctrl,
	input  k6502Pkg::status_t          status,
	input  logic [`K6502_DATA_W-1:0]   regData,
	input  logic [`K6502_DATA_W-1:0]   aluResult,
	output k6502Pkg::memReq_t          memReq,
	output logic                       memValid,
	input  logic                       memReady,
	input  logic [`K6502_DATA_W-1:0]   memRdata,
	output logic [7:0]                 ir,
	output logic [`K6502_CYC_W-1:0]    cycle,
	output logic [`K6502_DATA_W-1:0]   dataIn,
	output logic                       step,
	output logic                       halted
);
	import k6502Pkg::*;

	logic [`K6502_ADDR_W-1:0] pc;
	logic [`K6502_DATA_W-1:0] dl;
	logic     vecActive;
	logic     active;
	logic     illegalNow;
	addrSel_t addrSel;

	assign illegalNow = ctrl.illegal & ~vecActive;
	assign memValid   = active & ~halted & ~illegalNow;
	assign step       = memValid & memReady;
	assign dataIn     = memRdata;
	assign addrSel    = vecActive ? AddrVec : ctrl.addrSel;

	always_comb begin
		case (addrSel)
			AddrZp:  memReq.addr = `K6502_ZP_BASE | {8'h00, dl};
			AddrVec: memReq.addr = `K6502_RST_VEC | {15'd0, cycle[0]};
			default: memReq.addr = pc;
		endcase
		memReq.write = ctrl.memWrite & ~vecActive;
		case (ctrl.dataSel)
			DataAlu: memReq.wdata = aluResult;
			DataReg: memReq.wdata = regData;
			default: memReq.wdata = memRdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			active    <= 1'b0;
			halted    <= 1'b0;
			vecActive <= 1'b1;
			cycle     <= '0;
			ir        <= 8'hEA;
		end else begin
			active <= 1'b1;
			if (active && illegalNow)
				halted <= 1'b1;
			if (step) begin
				if (vecActive) begin
					// Two vector reads, then start fetching
					if (cycle[0]) begin
						vecActive <= 1'b0;
						cycle     <= '0;
					end else begin
						cycle <= cycle + 1'b1;
					end
				end else begin
					if (cycle == '0)
						ir <= memRdata;
					cycle <= ctrl.last ? '0 : cycle + 1'b1;
				end
			end
		end
	end

	// PC and data latch
	always_ff @(posedge clk) begin
		if (step) begin
			if (vecActive || ctrl.dlLoad)
				dl <= memRdata;
			if (vecActive) begin
				if (cycle[0])
					pc <= {memRdata, dl};
			end else if (ctrl.pcLoadAbs) begin
				pc <= {memRdata, dl};
			end else if (ctrl.pcLoadRel) begin
				pc <= pc + {{8{dl[7]}}, dl};
			end else if (ctrl.pcInc) begin
				pc <= pc + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		memValid && !memReady |=> memValid && $stable(memReq))
		else $error("memory request changed while stalled");

endmodule

//--- src/k6502Top.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Top (
	input  logic                       clk,
	input  logic                       rstN,
	output k6502Pkg::memReq_t          memReq,
	output logic                       memValid,
	input  logic                       memReady,
	input  logic [`K6502_DATA_W-1:0]   memRdata,
	output logic                       halted
);
	import k6502Pkg::*;

	ctrlWord_t ctrl;
	status_t   status;
	flagMask_t aluFlags;
	logic [7:0]               ir;
	logic [`K6502_CYC_W-1:0]  cycle;
	logic [`K6502_DATA_W-1:0] dataIn, regData, aluOperand, aluResult;
	logic step;

	k6502Seq u_seq (
		.clk(clk), .rstN(rstN), .ctrl(ctrl), .status(status),
		.regData(regData), .aluResult(aluResult),
		.memReq(memReq), .memValid(memValid), .memReady(memReady), .memRdata(memRdata),
		.ir(ir), .cycle(cycle), .dataIn(dataIn), .step(step), .halted(halted)
	);

	k6502Decode u_decode (
		.ir(ir), .cycle(cycle), .status(status), .ctrl(ctrl)
	);

	k6502Regs u_regs (
		.clk(clk), .rstN(rstN), .step(step), .ctrl(ctrl),
		.aluResult(aluResult), .aluFlags(aluFlags), .dataIn(dataIn),
		.regData(regData), .aluOperand(aluOperand), .status(status)
	);

	// Second operand always comes off the data-in byte
	k6502Alu u_alu (
		.op(ctrl.aluOp), .a(aluOperand), .b(dataIn), .carryIn(status.c),
		.result(aluResult), .flags(aluFlags)
	);

endmodule

//--- bench/k6502Mem.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Mem (
	input  logic                       clk,
	input  k6502Pkg::memReq_t          req,
	input  logic                       valid,
	output logic                       ready,
	output logic [`K6502_DATA_W-1:0]   rdata
);

	// Full 64 KiB, loaded by the testbench before reset is released
	logic [`K6502_DATA_W-1:0] mem [0:(1 << `K6502_ADDR_W) - 1];

	// Read data follows the request address in the same cycle
	assign rdata = mem[req.addr];

	// Ready drops on roughly a third of the cycles
	initial begin
		ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			ready = ($urandom % 3) != 0;
		end
	end

	always @(posedge clk) begin
		if (valid && ready && req.write)
			mem[req.addr] <= req.wdata;
	end

endmodule

//--- bench/k6502Tb.sv
`timescale 1ns/100ps
`include "k6502_defs.svh"

module k6502Tb;
	import k6502Pkg::*;

	localparam logic [15:0] progBase = 16'h0400;
	localparam int numBlocks = 48;
	localparam logic [23:0] loadZpOps = {8'hA5, 8'hA6, 8'hA4};
	localparam logic [31:0] xferOps = {8'hAA, 8'hA8, 8'h8A, 8'h98};
	localparam logic [39:0] aluImmOps = {8'h69, 8'hE9, 8'h29, 8'h09, 8'h49};
	localparam logic [47:0] cmpFlagOps = {8'hC9, 8'hE0, 8'hC0, 8'h18, 8'h38, 8'hB8};
	localparam logic [63:0] branchOps = {8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0};
	localparam logic [31:0] shiftOps = {8'h0A, 8'h2A, 8'h4A, 8'h6A};
	localparam logic [31:0] countOps = {8'hE8, 8'hC8, 8'hCA, 8'h88};
	localparam logic [15:0] carryOps = {8'h18, 8'h38};

	logic clk;
	logic rstN;
	memReq_t memReq;
	logic memValid, memReady, halted;
	logic [`K6502_DATA_W-1:0] memRdata;

	logic [7:0] refMem [0:65535];
	memReq_t expWrites [$];
	logic [15:0] emitPc;
	int progLen;
	int unsigned timeLimit;
	int writeErrors, haltErrors, busErrors;

	k6502Top u_k6502Top (
		.clk(clk), .rstN(rstN), .memReq(memReq), .memValid(memValid),
		.memReady(memReady), .memRdata(memRdata), .halted(halted)
	);

	k6502Mem u_mem (
		.clk(clk), .req(memReq), .valid(memValid), .ready(memReady), .rdata(memRdata)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [7:0] pickOp(input logic [63:0] ops, input int count);
		int idx;
		idx = $urandom_range(count - 1);
		return ops[8 * idx +: 8];
	endfunction

	function automatic logic [7:0] fillByte(input logic [15:0] addr);
		return addr[7:0] ^ {addr[12:8], addr[15:13]} ^ 8'h3C;
	endfunction

	task automatic putByte(input logic [15:0] addr, input logic [7:0] data);
		u_mem.mem[addr] = data;
		refMem[addr] = data;
	endtask

	task automatic emit(input logic [7:0] data);
		putByte(emitPc, data);
		emitPc = emitPc + 16'd1;
	endtask

	task automatic emit2(input logic [7:0] op, input logic [7:0] operand);
		emit(op);
		emit(operand);
	endtask

	task automatic buildProgram();
		logic [15:0] target;
		logic [7:0] op;
		for (int i = 0; i < 65536; i++)
			putByte(16'(i), fillByte(16'(i)));
		putByte(`K6502_RST_VEC, progBase[7:0]);
		putByte(`K6502_RST_VEC + 16'd1, progBase[15:8]);
		emitPc = progBase;
		for (int blk = 0; blk < numBlocks; blk++) begin
			emit2(8'hA9, 8'($urandom));
			emit2(8'hA2, 8'($urandom));
			emit2(8'hA0, 8'($urandom));
			case ($urandom_range(4))
				0: begin
					emit2(pickOp(loadZpOps, 3), 8'($urandom));
					emit(pickOp(xferOps, 4));
				end
				1: begin
					emit(pickOp(carryOps, 2));
					emit2(pickOp(aluImmOps, 5), 8'($urandom));
				end
				2: begin
					op = pickOp(cmpFlagOps, 6);
					if (op == 8'h18 || op == 8'h38 || op == 8'hB8)
						emit(op);
					else
						emit2(op, 8'($urandom));
					// Taken branch skips the two-byte marker store
					emit2(pickOp(branchOps, 8), 8'h02);
					emit2(8'h85, 8'hC0 + 8'(blk));
				end
				3: begin
					emit(pickOp(carryOps, 2));
					emit(pickOp(shiftOps, 4));
					emit(pickOp(shiftOps, 4));
					emit(pickOp(countOps, 4));
					emit(pickOp(countOps, 4));
				end
				default: begin
					emit(8'hEA);
					// JMP lands just past an illegal byte
					target = emitPc + 16'd4;
					emit(8'h4C);
					emit2(target[7:0], target[15:8]);
					emit(8'h02);
				end
			endcase
			emit2(8'h85, 8'h10 + 8'(3 * blk));
			emit2(8'h86, 8'h11 + 8'(3 * blk));
			emit2(8'h84, 8'h12 + 8'(3 * blk));
		end
		emit(8'h02);
		progLen = emitPc - progBase;
	endtask

	// Instruction-level 6502 model, queues every store it performs
	function automatic int refRun();
		logic [15:0] pc;
		logic [7:0] a, x, y, op, opnd, hi, r, cmpVal;
		logic n, v, z, c, taken;
		int sum;
		int count;
		pc = {refMem[`K6502_RST_VEC + 16'd1], refMem[`K6502_RST_VEC]};
		{a, x, y} = '0;
		{n, v, z, c} = '0;
		for (count = 0; count < 100000; count++) begin
			op = refMem[pc];
			opnd = refMem[pc + 16'd1];
			hi = refMem[pc + 16'd2];
			cmpVal = (op == 8'hE0) ? x : (op == 8'hC0) ? y : a;
			taken = 1'b0;
			sum = 0;
			case (op)
				8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'hE8, 8'hC8, 8'hCA, 8'h88,
				8'hAA, 8'hA8, 8'h8A, 8'h98, 8'h18, 8'h38, 8'hB8, 8'hEA, 8'h4C:
					pc = pc + 16'd1;
				default: pc = pc + 16'd2;
			endcase
			case (op)
				8'hA9: a = opnd;
				8'hA2: x = opnd;
				8'hA0: y = opnd;
				8'hA5: a = refMem[{8'h00, opnd}];
				8'hA6: x = refMem[{8'h00, opnd}];
				8'hA4: y = refMem[{8'h00, opnd}];
				8'h85, 8'h86, 8'h84: begin
					r = (op == 8'h85) ? a : (op == 8'h86) ? x : y;
					refMem[{8'h00, opnd}] = r;
					expWrites.push_back('{addr: {8'h00, opnd}, write: 1'b1, wdata: r});
				end
				8'h69: begin
					sum = a + opnd + c;
					v = ((a ^ sum[7:0]) & (opnd ^ sum[7:0]) & 8'h80) != 0;
					c = sum > 255;
					a = sum[7:0];
				end
				8'hE9: begin
					sum = a - opnd - !c;
					v = ((a ^ opnd) & (a ^ sum[7:0]) & 8'h80) != 0;
					c = sum >= 0;
					a = sum[7:0];
				end
				8'h29: a = a & opnd;
				8'h09: a = a | opnd;
				8'h49: a = a ^ opnd;
				8'hC9, 8'hE0, 8'hC0: begin
					sum = cmpVal - opnd;
					c = cmpVal >= opnd;
				end
				8'h0A: begin
					c = a[7];
					a = a << 1;
				end
				8'h2A: begin
					r = a;
					a = {a[6:0], c};
					c = r[7];
				end
				8'h4A: begin
					c = a[0];
					a = a >> 1;
				end
				8'h6A: begin
					r = a;
					a = {c, a[7:1]};
					c = r[0];
				end
				8'hE8: x = x + 8'd1;
				8'hC8: y = y + 8'd1;
				8'hCA: x = x - 8'd1;
				8'h88: y = y - 8'd1;
				8'hAA: x = a;
				8'hA8: y = a;
				8'h8A: a = x;
				8'h98: a = y;
				8'h18: c = 1'b0;
				8'h38: c = 1'b1;
				8'hB8: v = 1'b0;
				8'h10: taken = !n;
				8'h30: taken = n;
				8'h50: taken = !v;
				8'h70: taken = v;
				8'h90: taken = !c;
				8'hB0: taken = c;
				8'hD0: taken = !z;
				8'hF0: taken = z;
				8'h4C: pc = {hi, opnd};
				8'hEA: ;
				default: return count;
			endcase
			if (taken)
				pc = pc + {{8{opnd[7]}}, opnd};
			case (op)
				8'hA2, 8'hA6, 8'hE8, 8'hCA, 8'hAA: {n, z} = {x[7], x == 8'h00};
				8'hA0, 8'hA4, 8'hC8, 8'h88, 8'hA8: {n, z} = {y[7], y == 8'h00};
				8'hC9, 8'hE0, 8'hC0: {n, z} = {sum[7], sum[7:0] == 8'h00};
				8'hA9, 8'hA5, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49, 8'h0A, 8'h2A,
				8'h4A, 8'h6A, 8'h8A, 8'h98: {n, z} = {a[7], a == 8'h00};
				default: ;
			endcase
		end
		return count;
	endfunction

	task automatic checkWrite(input memReq_t got);
		memReq_t exp;
		if (expWrites.size() == 0) begin
			busErrors++;
			$display("unexpected write to address %h after the last expected write", got.addr);
		end else begin
			exp = expWrites.pop_front();
			if (got.addr !== exp.addr) begin
				writeErrors++;
				$display("FAIL memReq.addr got %h expected %h", got.addr, exp.addr);
			end
			if (got.wdata !== exp.wdata) begin
				writeErrors++;
				$display("FAIL memReq.wdata got %h expected %h", got.wdata, exp.wdata);
			end
		end
	endtask

	task automatic checkHalt(input logic haltedNow);
		if (haltedNow !== 1'b1) begin
			haltErrors++;
			$display("core did not halt at the end of the program");
		end
		if (expWrites.size() != 0) begin
			haltErrors++;
			$display("core halted with %0d expected writes still missing", expWrites.size());
		end
	endtask

	task automatic printCounts();
		$display("errors: write %0d, halt %0d, bus %0d", writeErrors, haltErrors, busErrors);
	endtask

	// Request, valid and ready are settled by the falling edge
	always @(negedge clk) begin
		if (rstN && memValid && memReady && memReq.write)
			checkWrite(memReq);
		if (rstN && halted && memValid) begin
			busErrors++;
			$display("bus request raised after halt");
		end
	end

	initial begin : mainFlow
		int instrs;
		rstN = 1'b0;
		writeErrors = 0;
		haltErrors = 0;
		busErrors = 0;
		void'($urandom(32'h6d979b69));
		buildProgram();
		instrs = refRun();
		$display("reference run: %0d instructions, %0d writes", instrs, expWrites.size());
		// Program bytes, cycles per step, stall factor, clock period
		timeLimit = (progLen + 8) * 8 * 4 * 20;
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;
		while (!halted && expWrites.size() != 0)
			@(posedge clk);
		for (int i = 0; i < 64 && !halted; i++)
			@(posedge clk);
		repeat (16) @(posedge clk);
		checkHalt(halted);
		printCounts();
		if (writeErrors + haltErrors + busErrors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		wait (timeLimit != 0);
		#(timeLimit);
		$display("timeout: run did not finish within %0d ns", timeLimit);
		printCounts();
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
+incdir+include
src/k6502Pkg.sv
src/k6502Alu.sv
src/k6502Decode.sv
src/k6502Regs.sv
src/k6502Seq.sv
src/k6502Top.sv
bench/k6502Mem.sv
bench/k6502Tb.sv
